// ==== all.f ====
bf_pkg.sv
bf_delay_table.sv
bf_beam_seq.sv
bf_stave_fetch.sv
bf_iram_arbiter.sv
bf_stave_adder.sv
bf_top.sv
bf_tb_ram.sv
bf_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= bf_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Done: no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bf_tb.sv ====
module bf_tb import bf_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED       = 36498;
    localparam int LAT_MIN    = 1;                    // ram latency range, cycles
    localparam int LAT_MAX    = 3;
    localparam int BUSY_LIMIT = 50;                   // cycles to see o_busy
    localparam int END_LIMIT  = 20000;                // cycles to see o_calc_end

    logic                    clk, rst;
    logic                    param_valid, calc_start, bm_data_ready;
    logic [TBL_W-1:0]        param_cnt;
    logic [TAU_W-1:0]        param_data;
    logic                    iram_rd_en, iram_rd_valid;
    logic [ADDR_W-1:0]       iram_rd_addr, exp_rd_addr;
    logic [IRAM_W-1:0]       iram_rd_data;
    logic signed [SUM_W-1:0] bm_data, held_data, exp_now;
    logic                    bm_data_valid, calc_end, busy, xfer;
    logic [TAU_W-1:0]        tau_tb [BEAM_NUM * STAVE_NUM];  // delays written
    logic signed [SUM_W-1:0] exp_mem [2 * OUT_NUM];          // two calcs, beam-major
    int  seed = SEED;
    int  out_idx, end_cnt, ost, calc_base, rd_cnt;
    int  err_data, err_hold, err_ctrl, err_ram, err_wait;
    bit  started, ready_rand, timed_out;

    bf_top u_dut (
        .i_arst (clk), .i_clk156m (rst),
        .i_param_valid (param_valid), .i_param_cnt (param_cnt), .i_param_data (param_data),
        .i_calc_start (calc_start),
        .o_iram_rd_en (iram_rd_en), .o_iram_rd_addr (iram_rd_addr),
        .i_iram_rd_valid (iram_rd_valid), .i_iram_rd_data (iram_rd_data),
        .o_bm_data (bm_data), .o_bm_data_valid (bm_data_valid),
        .i_bm_data_ready (bm_data_ready), .o_calc_end (calc_end), .o_busy (busy)
    );

    bf_tb_ram #(.SEED(SEED), .LAT_MIN(LAT_MIN), .LAT_MAX(LAT_MAX)) u_ram (
        .i_arst (clk), .i_rd_en (iram_rd_en), .i_rd_addr (iram_rd_addr),
        .o_rd_valid (iram_rd_valid), .o_rd_data (iram_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                        // 125 MHz
    end

    assign xfer    = bm_data_valid && bm_data_ready;
    assign exp_now = exp_mem[out_idx];

    // expected read address from the current job and the stave being read
    always_comb begin
        int job;
        int stv;
        job         = (rd_cnt % (OUT_NUM * STAVE_NUM)) / STAVE_NUM;  // 8 reads per job
        stv         = int'(iram_rd_addr) / STAVE_STRIDE;             // stave it serves
        exp_rd_addr = ADDR_W'(stv * STAVE_STRIDE + job % SAMPLE_NUM
                              + int'(tau_tb[(job / SAMPLE_NUM) * STAVE_NUM + stv]));
    end

    // ------------------------------------------------------------------
    // scoreboard counters
    // ------------------------------------------------------------------
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            out_idx <= 0;
            end_cnt <= 0;
            ost     <= 0;
            rd_cnt  <= 0;
        end else begin
            if (xfer)
                out_idx <= out_idx + 1;               // results across all calcs
            if (calc_end)
                end_cnt <= end_cnt + 1;
            if (iram_rd_en)
                rd_cnt <= rd_cnt + 1;                 // reads across all calcs
            ost <= ost + int'(iram_rd_en) - int'(iram_rd_valid);  // reads in flight
        end
    end

    always @(posedge clk)
        held_data <= bm_data;                         // last cycle's output

    always @(posedge clk) begin
        #1;
        if (ready_rand)
            bm_data_ready = ($random(seed) & 3) != 0; // stall about one cycle in four
        else
            bm_data_ready = 1'b1;
    end

    task automatic report_value(input string name, input logic signed [31:0] got,
                                input logic signed [31:0] exp);
        $display("FAILED t=%0t %s got %0d expected %0d", $time, name, got, exp);
    endtask

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------
    a_idle: assert property (@(posedge clk)
        !started |-> {iram_rd_en, bm_data_valid, calc_end, busy} == 4'b0)
        else begin
            err_ctrl = err_ctrl + 1;
            report_value("{o_iram_rd_en,o_bm_data_valid,o_calc_end,o_busy}",
                         $sampled({iram_rd_en, bm_data_valid, calc_end, busy}), 0);
        end
    a_data: assert property (@(posedge clk) disable iff (rst)
        xfer |-> (out_idx < calc_base + OUT_NUM) && (bm_data == exp_now))
        else begin
            err_data = err_data + 1;
            report_value("o_bm_data", $sampled(bm_data), $sampled(exp_now));
        end
    a_hold_valid: assert property (@(posedge clk) disable iff (rst)
        (bm_data_valid && !bm_data_ready) |=> bm_data_valid)
        else begin
            err_hold = err_hold + 1;
            report_value("o_bm_data_valid", $sampled(bm_data_valid), 1);
        end
    a_hold_data: assert property (@(posedge clk) disable iff (rst)
        (bm_data_valid && !bm_data_ready) |=> bm_data == held_data)
        else begin
            err_hold = err_hold + 1;
            report_value("o_bm_data", $sampled(bm_data), $sampled(held_data));
        end
    a_end_after: assert property (@(posedge clk) disable iff (rst)
        (xfer && out_idx == calc_base + OUT_NUM - 1) |=> calc_end)
        else begin
            err_ctrl = err_ctrl + 1;
            report_value("o_calc_end", $sampled(calc_end), 1);
        end
    a_end_only: assert property (@(posedge clk) disable iff (rst)
        calc_end |-> (out_idx == calc_base + OUT_NUM) && !busy)
        else begin
            err_ctrl = err_ctrl + 1;
            $display("o_calc_end at t=%0t came early or with o_busy high", $time);
        end
    a_start: assert property (@(posedge clk) disable iff (rst) calc_start |=> busy)
        else begin
            err_ctrl = err_ctrl + 1;
            report_value("o_busy", $sampled(busy), 1);
        end
    a_addr: assert property (@(posedge clk) disable iff (rst)
        iram_rd_en |-> iram_rd_addr == exp_rd_addr)
        else begin
            err_ram = err_ram + 1;
            report_value("o_iram_rd_addr", $sampled(iram_rd_addr), $sampled(exp_rd_addr));
        end
    a_ost: assert property (@(posedge clk) disable iff (rst) ost <= MAX_OUTSTANDING)
        else begin
            err_ram = err_ram + 1;
            $display("more than %0d ram reads in flight at t=%0t", MAX_OUTSTANDING, $time);
        end

    // ------------------------------------------------------------------
    // stimulus and reference model
    // ------------------------------------------------------------------
    task automatic load_delays();
        for (int i = 0; i < BEAM_NUM * STAVE_NUM; i++) begin
            @(posedge clk);
            #1;
            param_valid = 1'b1;
            param_cnt   = TBL_W'(i);
            param_data  = TAU_W'($random(seed));
            tau_tb[i]   = param_data;
        end
        @(posedge clk);
        #1;
        param_valid = 1'b0;
    endtask

    // sum over staves of ram[s*STRIDE + n + tau(b,s)], low half signed
    task automatic build_expected(input int base);
        int                      acc;
        int                      addr;
        logic signed [SMP_W-1:0] smp;
        for (int b = 0; b < BEAM_NUM; b++) begin
            for (int n = 0; n < SAMPLE_NUM; n++) begin
                acc = 0;
                for (int s = 0; s < STAVE_NUM; s++) begin
                    addr = s * STAVE_STRIDE + n + int'(tau_tb[b * STAVE_NUM + s]);
                    smp  = u_ram.mem[addr][SMP_W-1:0];
                    acc  = acc + int'(smp);
                end
                exp_mem[base + b * SAMPLE_NUM + n] = SUM_W'(acc);
            end
        end
    endtask

    task automatic run_calc(input int num, input bit poke_busy);
        int n;
        load_delays();
        build_expected(num * OUT_NUM);
        @(negedge clk);
        calc_base  = num * OUT_NUM;
        ready_rand = 1'b1;
        @(posedge clk);
        #1;
        started    = 1'b1;
        calc_start = 1'b1;
        @(posedge clk);
        #1;
        calc_start = 1'b0;
        n = 0;
        while (!busy && n < BUSY_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!busy) begin
            err_wait  = err_wait + 1;
            timed_out = 1'b1;
            $display("o_busy never rose after the start of calculation %0d", num);
        end
        if (poke_busy && !timed_out) begin
            repeat (20) @(posedge clk);
            #1;
            calc_start = 1'b1;                        // must be ignored
            @(posedge clk);
            #1;
            calc_start = 1'b0;
        end
        n = 0;
        while (!timed_out && end_cnt <= num && n < END_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!timed_out && end_cnt <= num) begin
            err_wait  = err_wait + 1;
            timed_out = 1'b1;
            $display("no o_calc_end within %0d cycles in calculation %0d", END_LIMIT, num);
        end
        if (!timed_out) begin
            repeat (4) @(posedge clk);
            #1;
            assert (end_cnt == num + 1) else begin
                err_ctrl = err_ctrl + 1;
                $display("calculation %0d gave %0d end pulses in total, not one each",
                         num, end_cnt);
            end
            assert (out_idx == calc_base + OUT_NUM) else begin
                err_data = err_data + 1;
                report_value("o_bm_data transfers", out_idx, calc_base + OUT_NUM);
            end
        end
        @(negedge clk);
        ready_rand = 1'b0;
    endtask

    initial begin
        int total;
        rst           = 1'b0;
        param_valid   = 1'b0;
        param_cnt     = '0;
        param_data    = '0;
        calc_start    = 1'b0;
        bm_data_ready = 1'b1;
        #1;
        rst = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (4) @(posedge clk);
        run_calc(0, 1'b1);                            // start pulse while busy
        if (!timed_out)
            run_calc(1, 1'b0);                        // fresh delays
        total = err_data + err_hold + err_ctrl + err_ram + err_wait;
        $display("errors: data %0d, hold %0d, control %0d, ram %0d, timeout %0d",
                 err_data, err_hold, err_ctrl, err_ram, err_wait);
        if (total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== bf_tb_ram.sv ====
module bf_tb_ram import bf_pkg::*; #(
    parameter int SEED    = 1,                   // fill and latency seed
    parameter int LAT_MIN = 1,                   // cycles, enable to valid
    parameter int LAT_MAX = 3
) (
    input  logic              i_arst,            // clock
    input  logic              i_rd_en,
    input  logic [ADDR_W-1:0] i_rd_addr,
    output logic              o_rd_valid,
    output logic [IRAM_W-1:0] o_rd_data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [IRAM_W-1:0] mem [2**ADDR_W];          // read by the reference model too
    int                seed;
    longint            cyc;                      // edge counter
    longint            last_due;                 // return cycle of previous read
    longint            due_q [$];                // pending return cycles, in order
    logic [IRAM_W-1:0] data_q [$];               // pending read data

    // ------------------------------------------------------------------
    // random fill over the whole address range
    // ------------------------------------------------------------------
    initial begin
        seed       = SEED;
        cyc        = 0;
        last_due   = 0;
        o_rd_valid = 1'b0;
        o_rd_data  = '0;
        for (int a = 0; a < 2**ADDR_W; a++)
            mem[a] = $random(seed);
    end

    // enables sampled on the edge, returns driven just after it
    always @(posedge i_arst) begin
        int     lat;
        longint due;
        cyc = cyc + 1;
        if (i_rd_en) begin
            lat = LAT_MIN + int'($unsigned($random(seed)) % (LAT_MAX - LAT_MIN + 1));
            due = cyc + lat;
            if (due <= last_due)
                due = last_due + 1;              // keep returns in request order
            last_due = due;
            due_q.push_back(due);
            data_q.push_back(mem[i_rd_addr]);
        end
        #1;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            o_rd_valid = 1'b1;
            o_rd_data  = data_q.pop_front();
            void'(due_q.pop_front());
        end else begin
            o_rd_valid = 1'b0;                   // data left as is
        end
    end

endmodule

// ==== bf_top.sv ====
module bf_top import bf_pkg::*; (
    input  logic                    i_arst,              // clock
    input  logic                    i_clk156m,           // async reset, active high
    input  logic                    i_param_valid,       // delay table write
    input  logic [TBL_W-1:0]        i_param_cnt,         // table index
    input  logic [TAU_W-1:0]        i_param_data,        // sample delay
    input  logic                    i_calc_start,        // start pulse
    output logic                    o_iram_rd_en,
    output logic [ADDR_W-1:0]       o_iram_rd_addr,
    input  logic                    i_iram_rd_valid,
    input  logic [IRAM_W-1:0]       i_iram_rd_data,
    output logic signed [SUM_W-1:0] o_bm_data,           // beam sample
    output logic                    o_bm_data_valid,
    input  logic                    i_bm_data_ready,
    output logic                    o_calc_end,          // end of calculation
    output logic                    o_busy
);
    logic                    w_job_valid;
    logic                    w_job_ready0, w_job_ready1;
    logic [BEAM_W-1:0]       w_job_beam;
    logic [SMPL_W-1:0]       w_job_sample;
    logic [TBL_W-1:0]        w_tbl_idx0, w_tbl_idx1;
    logic [TAU_W-1:0]        w_tau0, w_tau1;
    logic                    w_req_valid0, w_req_valid1;
    logic                    w_req_ready0, w_req_ready1;
    logic [ADDR_W-1:0]       w_req_addr0, w_req_addr1;
    logic                    w_rsp_valid0, w_rsp_valid1;
    logic [IRAM_W-1:0]       w_rsp_data;
    logic                    w_psum_valid0, w_psum_valid1;
    logic                    w_psum_ready0, w_psum_ready1;
    logic signed [SUM_W-1:0] w_psum0, w_psum1;
    logic                    w_out_done;

    bf_beam_seq u_seq (
        .i_arst, .i_clk156m, .i_calc_start,
        .i_job_ready0 (w_job_ready0), .i_job_ready1 (w_job_ready1),
        .i_out_done   (w_out_done),   .o_job_valid  (w_job_valid),
        .o_job_beam   (w_job_beam),   .o_job_sample (w_job_sample),
        .o_calc_end, .o_busy
    );

    bf_delay_table u_table (
        .i_arst, .i_clk156m, .i_param_valid, .i_param_cnt, .i_param_data,
        .i_rd_idx0 (w_tbl_idx0), .i_rd_idx1 (w_tbl_idx1),
        .o_tau0    (w_tau0),     .o_tau1    (w_tau1)
    );

    // even staves
    bf_stave_fetch #(.LANE(0)) u_fetch0 (
        .i_arst, .i_clk156m,
        .i_job_valid  (w_job_valid),   .i_job_beam  (w_job_beam),  .i_job_sample (w_job_sample),
        .i_tau        (w_tau0),        .i_req_ready (w_req_ready0),
        .i_rsp_valid  (w_rsp_valid0),  .i_rsp_data  (w_rsp_data),  .i_psum_ready (w_psum_ready0),
        .o_job_ready  (w_job_ready0),  .o_tbl_idx   (w_tbl_idx0),
        .o_req_valid  (w_req_valid0),  .o_req_addr  (w_req_addr0),
        .o_psum_valid (w_psum_valid0), .o_psum      (w_psum0)
    );

    // odd staves
    bf_stave_fetch #(.LANE(1)) u_fetch1 (
        .i_arst, .i_clk156m,
        .i_job_valid  (w_job_valid),   .i_job_beam  (w_job_beam),  .i_job_sample (w_job_sample),
        .i_tau        (w_tau1),        .i_req_ready (w_req_ready1),
        .i_rsp_valid  (w_rsp_valid1),  .i_rsp_data  (w_rsp_data),  .i_psum_ready (w_psum_ready1),
        .o_job_ready  (w_job_ready1),  .o_tbl_idx   (w_tbl_idx1),
        .o_req_valid  (w_req_valid1),  .o_req_addr  (w_req_addr1),
        .o_psum_valid (w_psum_valid1), .o_psum      (w_psum1)
    );

    bf_iram_arbiter u_arb (
        .i_arst, .i_clk156m,
        .i_req_valid0 (w_req_valid0), .i_req_addr0 (w_req_addr0),
        .i_req_valid1 (w_req_valid1), .i_req_addr1 (w_req_addr1),
        .i_iram_rd_valid, .i_iram_rd_data,
        .o_req_ready0 (w_req_ready0), .o_req_ready1 (w_req_ready1),
        .o_iram_rd_en, .o_iram_rd_addr,
        .o_rsp_valid0 (w_rsp_valid0), .o_rsp_valid1 (w_rsp_valid1), .o_rsp_data (w_rsp_data)
    );

    bf_stave_adder u_add (
        .i_arst, .i_clk156m,
        .i_psum_valid0 (w_psum_valid0), .i_psum0 (w_psum0),
        .i_psum_valid1 (w_psum_valid1), .i_psum1 (w_psum1),
        .i_bm_data_ready,
        .o_psum_ready0 (w_psum_ready0), .o_psum_ready1 (w_psum_ready1),
        .o_bm_data, .o_bm_data_valid, .o_out_done (w_out_done)
    );

endmodule

// ==== bf_stave_adder.sv ====
module bf_stave_adder import bf_pkg::*; (
    input  logic                    i_arst,          // clock
    input  logic                    i_clk156m,       // async reset
    input  logic                    i_psum_valid0,   // even staves
    input  logic signed [SUM_W-1:0] i_psum0,
    input  logic                    i_psum_valid1,   // odd staves
    input  logic signed [SUM_W-1:0] i_psum1,
    input  logic                    i_bm_data_ready,
    output logic                    o_psum_ready0,
    output logic                    o_psum_ready1,
    output logic signed [SUM_W-1:0] o_bm_data,
    output logic                    o_bm_data_valid,
    output logic                    o_out_done       // result accepted
);
    logic w_free;                                    // output reg can load
    logic w_take;                                    // both lanes joined

    assign w_free        = !o_bm_data_valid || i_bm_data_ready;
    assign o_psum_ready0 = w_free && i_psum_valid1;  // only together
    assign o_psum_ready1 = w_free && i_psum_valid0;
    assign w_take        = w_free && i_psum_valid0 && i_psum_valid1;
    assign o_out_done    = o_bm_data_valid && i_bm_data_ready;

    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            o_bm_data_valid <= 1'b0;
        end else if (w_take) begin
            o_bm_data_valid <= 1'b1;
        end else if (o_out_done) begin
            o_bm_data_valid <= 1'b0;
        end
    end

    // holds while valid and not ready
    always_ff @(posedge i_arst) begin
        if (w_take)
            o_bm_data <= i_psum0 + i_psum1;
    end

endmodule

// ==== bf_iram_arbiter.sv ====
module bf_iram_arbiter import bf_pkg::*; (
    input  logic              i_arst,            // clock
    input  logic              i_clk156m,         // async reset
    input  logic              i_req_valid0,
    input  logic [ADDR_W-1:0] i_req_addr0,
    input  logic              i_req_valid1,
    input  logic [ADDR_W-1:0] i_req_addr1,
    input  logic              i_iram_rd_valid,   // in-order return
    input  logic [IRAM_W-1:0] i_iram_rd_data,
    output logic              o_req_ready0,      // grant lane 0
    output logic              o_req_ready1,      // grant lane 1
    output logic              o_iram_rd_en,
    output logic [ADDR_W-1:0] o_iram_rd_addr,
    output logic              o_rsp_valid0,
    output logic              o_rsp_valid1,
    output logic [IRAM_W-1:0] o_rsp_data
);
    logic             r_last;                    // last winner, 1 = lane 1
    logic [OST_W-1:0] r_outst;                   // granted, not yet returned
    logic             r_own [MAX_OUTSTANDING];   // owner queue
    logic             r_wr_ptr;
    logic             r_rd_ptr;
    logic             r_rsp_valid;
    logic             r_rsp_own;
    logic             w_room;
    logic             w_gnt;

    assign w_room       = (r_outst < OST_W'(MAX_OUTSTANDING));
    assign o_req_ready0 = w_room && i_req_valid0 && (!i_req_valid1 || r_last);
    assign o_req_ready1 = w_room && i_req_valid1 && (!i_req_valid0 || !r_last);
    assign w_gnt        = o_req_ready0 || o_req_ready1;

    // ------------------------------------------------------------------
    // grant, outstanding count and owner queue pointers
    // ------------------------------------------------------------------
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_last       <= 1'b0;
            r_outst      <= '0;
            r_wr_ptr     <= 1'b0;
            r_rd_ptr     <= 1'b0;
            o_iram_rd_en <= 1'b0;
            r_rsp_valid  <= 1'b0;
        end else begin
            o_iram_rd_en <= w_gnt;                   // one cycle after grant
            r_rsp_valid  <= i_iram_rd_valid;         // return register
            r_outst      <= r_outst + OST_W'(w_gnt) - OST_W'(i_iram_rd_valid);
            if (w_gnt) begin
                r_last   <= o_req_ready1;
                r_wr_ptr <= !r_wr_ptr;
            end
            if (i_iram_rd_valid)
                r_rd_ptr <= !r_rd_ptr;
        end
    end

    always_ff @(posedge i_arst) begin
        if (w_gnt) begin
            r_own[r_wr_ptr] <= o_req_ready1;
            o_iram_rd_addr  <= o_req_ready1 ? i_req_addr1 : i_req_addr0;
        end
        if (i_iram_rd_valid) begin
            r_rsp_own  <= r_own[r_rd_ptr];           // head of queue owns it
            o_rsp_data <= i_iram_rd_data;
        end
    end

    assign o_rsp_valid0 = r_rsp_valid && !r_rsp_own;
    assign o_rsp_valid1 = r_rsp_valid && r_rsp_own;

endmodule

// ==== bf_stave_fetch.sv ====
module bf_stave_fetch import bf_pkg::*; #(
    parameter int LANE = 0                           // 0 even staves, 1 odd staves
) (
    input  logic                    i_arst,          // clock
    input  logic                    i_clk156m,       // async reset
    input  logic                    i_job_valid,
    input  logic [BEAM_W-1:0]       i_job_beam,
    input  logic [SMPL_W-1:0]       i_job_sample,
    input  logic [TAU_W-1:0]        i_tau,           // delay for o_tbl_idx
    input  logic                    i_req_ready,     // arbiter grant
    input  logic                    i_rsp_valid,     // our read came back
    input  logic [IRAM_W-1:0]       i_rsp_data,
    input  logic                    i_psum_ready,
    output logic                    o_job_ready,
    output logic [TBL_W-1:0]        o_tbl_idx,
    output logic                    o_req_valid,
    output logic [ADDR_W-1:0]       o_req_addr,
    output logic                    o_psum_valid,
    output logic signed [SUM_W-1:0] o_psum
);
    logic              r_active;                     // job in progress
    logic              r_wait;                       // one read outstanding
    logic [LCNT_W-1:0] r_k;                          // stave step 0..3
    logic [BEAM_W-1:0] r_beam;
    logic [SMPL_W-1:0] r_sample;
    logic [STV_W-1:0]  w_stave;

    assign w_stave     = {r_k, 1'(LANE)};            // stave 2k+LANE
    assign o_tbl_idx   = {r_beam, w_stave};
    assign o_req_addr  = ADDR_W'(w_stave) * ADDR_W'(STAVE_STRIDE)
                       + ADDR_W'(r_sample) + ADDR_W'(i_tau);
    assign o_req_valid = r_active && !r_wait;
    assign o_job_ready = !r_active && !o_psum_valid; // free once psum taken

    // ------------------------------------------------------------------
    // control
    // ------------------------------------------------------------------
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_active     <= 1'b0;
            r_wait       <= 1'b0;
            r_k          <= '0;
            o_psum_valid <= 1'b0;
        end else begin
            if (i_job_valid && o_job_ready) begin
                r_active <= 1'b1;
                r_k      <= '0;
            end
            if (o_req_valid && i_req_ready)
                r_wait <= 1'b1;
            if (i_rsp_valid) begin
                r_wait <= 1'b0;
                if (r_k == LCNT_W'(LANE_STAVES - 1)) begin
                    r_active     <= 1'b0;
                    o_psum_valid <= 1'b1;            // one cycle after 4th return
                end else begin
                    r_k <= r_k + 1'b1;
                end
            end
            if (o_psum_valid && i_psum_ready)
                o_psum_valid <= 1'b0;
        end
    end

    // job fields and accumulator
    always_ff @(posedge i_arst) begin
        if (i_job_valid && o_job_ready) begin
            r_beam   <= i_job_beam;
            r_sample <= i_job_sample;
            o_psum   <= '0;
        end else if (i_rsp_valid) begin
            o_psum <= o_psum + SUM_W'(signed'(i_rsp_data[SMP_W-1:0]));  // sign extend
        end
    end

endmodule

// ==== bf_beam_seq.sv ====
module bf_beam_seq import bf_pkg::*; (
    input  logic              i_arst,            // clock
    input  logic              i_clk156m,         // async reset
    input  logic              i_calc_start,      // start pulse
    input  logic              i_job_ready0,      // lane 0 idle
    input  logic              i_job_ready1,      // lane 1 idle
    input  logic              i_out_done,        // one result left the adder
    output logic              o_job_valid,       // job to both lanes
    output logic [BEAM_W-1:0] o_job_beam,
    output logic [SMPL_W-1:0] o_job_sample,
    output logic              o_calc_end,
    output logic              o_busy
);
    seq_state_t        r_state;
    logic [OCNT_W-1:0] r_done_cnt;               // results accepted so far
    logic              w_last_job;
    logic              w_last_done;

    assign o_job_valid = (r_state == ISSUE) && i_job_ready0 && i_job_ready1;  // lanes in lockstep
    assign w_last_job  = (o_job_beam == BEAM_W'(BEAM_NUM - 1))
                      && (o_job_sample == SMPL_W'(SAMPLE_NUM - 1));
    assign w_last_done = i_out_done && (r_done_cnt == OCNT_W'(OUT_NUM - 1));
    assign o_calc_end  = (r_state == FINISH);
    assign o_busy      = (r_state == ISSUE) || (r_state == DRAIN);

    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            r_state      <= IDLE;
            o_job_beam   <= '0;
            o_job_sample <= '0;
            r_done_cnt   <= '0;
        end else begin
            if (i_out_done)
                r_done_cnt <= r_done_cnt + 1'b1;
            case (r_state)
                IDLE, FINISH: begin
                    r_state <= IDLE;
                    if (i_calc_start) begin              // busy is low here
                        r_state      <= ISSUE;
                        o_job_beam   <= '0;
                        o_job_sample <= '0;
                        r_done_cnt   <= '0;
                    end
                end
                ISSUE: begin
                    if (o_job_valid) begin
                        if (o_job_sample == SMPL_W'(SAMPLE_NUM - 1)) begin
                            o_job_sample <= '0;
                            o_job_beam   <= o_job_beam + 1'b1;   // next beam
                        end else begin
                            o_job_sample <= o_job_sample + 1'b1;
                        end
                        if (w_last_job)
                            r_state <= DRAIN;        // all jobs out
                    end
                end
                DRAIN: begin
                    if (w_last_done)
                        r_state <= FINISH;           // end pulse next cycle
                end
                default: r_state <= IDLE;
            endcase
        end
    end

endmodule

// ==== bf_delay_table.sv ====
module bf_delay_table import bf_pkg::*; (
    input  logic             i_arst,            // clock
    input  logic             i_clk156m,         // async reset
    input  logic             i_param_valid,     // write strobe
    input  logic [TBL_W-1:0] i_param_cnt,       // beam*STAVE_NUM + stave
    input  logic [TAU_W-1:0] i_param_data,      // delay in samples
    input  logic [TBL_W-1:0] i_rd_idx0,         // lane 0 lookup
    input  logic [TBL_W-1:0] i_rd_idx1,         // lane 1 lookup
    output logic [TAU_W-1:0] o_tau0,
    output logic [TAU_W-1:0] o_tau1
);
    logic [TAU_W-1:0] r_tau [BEAM_NUM * STAVE_NUM];

    // ------------------------------------------------------------------
    // register file, zero delays after reset
    // ------------------------------------------------------------------
    always_ff @(posedge i_arst or posedge i_clk156m) begin
        if (i_clk156m) begin
            for (int i = 0; i < BEAM_NUM * STAVE_NUM; i++)
                r_tau[i] <= '0;
        end else if (i_param_valid) begin
            r_tau[i_param_cnt] <= i_param_data;  // seen by readers next cycle
        end
    end

    // two combinational read ports
    assign o_tau0 = r_tau[i_rd_idx0];
    assign o_tau1 = r_tau[i_rd_idx1];

endmodule

// ==== bf_pkg.sv ====
package bf_pkg;

    // ------------------------------------------------------------------
    // array and calculation sizes
    // ------------------------------------------------------------------
    localparam int STAVE_NUM       = 8;                       // staves per output
    localparam int LANE_STAVES     = 4;                       // staves per fetch lane
    localparam int BEAM_NUM        = 4;                       // beams per calculation
    localparam int SAMPLE_NUM      = 16;                      // samples per beam
    localparam int OUT_NUM         = BEAM_NUM * SAMPLE_NUM;   // results per calculation
    localparam int STAVE_STRIDE    = 32;                      // ram words per stave
    localparam int MAX_OUTSTANDING = 2;                       // ram reads in flight

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------
    localparam int TAU_W   = 4;                               // integer delay
    localparam int ADDR_W  = 8;                               // input ram address
    localparam int IRAM_W  = 32;                              // input ram data
    localparam int SMP_W   = 16;                              // signed sample, low bits
    localparam int SUM_W   = 20;                              // signed result
    localparam int TBL_W   = 5;                               // beam*STAVE_NUM + stave
    localparam int BEAM_W  = 2;
    localparam int SMPL_W  = 4;
    localparam int STV_W   = $clog2(STAVE_NUM);               // stave number
    localparam int LCNT_W  = $clog2(LANE_STAVES);             // stave step in a lane
    localparam int OCNT_W  = $clog2(OUT_NUM);                 // result counter
    localparam int OST_W   = $clog2(MAX_OUTSTANDING + 1);     // outstanding reads

    // calculation sequencer states
    typedef enum logic [1:0] {
        IDLE,                                                 // wait for start
        ISSUE,                                                // hand out jobs
        DRAIN,                                                // wait for last result
        FINISH                                                // end pulse
    } seq_state_t;

endpackage
